// ==== equal_settings.svh ====
`ifndef EQUAL_SETTINGS_SVH
`define EQUAL_SETTINGS_SVH

// Memory address and noun field sizes
`define EQ_ADDR_WIDTH 8
`define EQ_NOUN_WIDTH 16

// Cell word is {hed tag, tel tag, hed, tel}
`define EQ_WORD_WIDTH (2 + 2 * `EQ_NOUN_WIDTH)
`define EQ_HED_TAG_BIT (`EQ_WORD_WIDTH - 1)
`define EQ_TEL_TAG_BIT (`EQ_WORD_WIDTH - 2)

// Pending address pairs held on chip
`define EQ_STACK_DEPTH 8

// Result cell contents
`define EQ_NIL {`EQ_NOUN_WIDTH{1'b1}}
`define EQ_YES {`EQ_NOUN_WIDTH{1'b0}}
`define EQ_NO {{(`EQ_NOUN_WIDTH - 1){1'b0}}, 1'b1}

`endif

// ==== noun_pkg.sv ====
package noun_pkg;

  // Tag of one cell field
  typedef enum logic {
    TAG_ATOM = 1'b0,
    TAG_CELL = 1'b1
  } tag_e;

  // Outcome of comparing one pair of fields
  typedef enum logic [1:0] {
    // Tags differ or atoms differ
    V_DIFFER  = 2'd0,
    // Same contents, subtrees equal
    V_SAME    = 2'd1,
    // Two cells at different addresses
    V_DESCEND = 2'd2
  } verdict_e;

endpackage

// ==== equal_ctrl_pkg.sv ====
package equal_ctrl_pkg;

  // Sequencer states
  typedef enum logic [2:0] {
    S_IDLE      = 3'd0,
    S_ROOT_REQ  = 3'd1,
    S_ROOT_WAIT = 3'd2,
    S_PAIR_REQ  = 3'd3,
    S_PAIR_WAIT = 3'd4,
    S_DECIDE    = 3'd5,
    S_WRITE     = 3'd6,
    S_REPORT    = 3'd7
  } state_e;

  // Memory request kind
  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_op_e;

endpackage

// ==== field_compare.sv ====
`include "equal_settings.svh"

module field_compare
  import noun_pkg::*;
(
  input  tag_e                      tag_a,
  input  logic [`EQ_NOUN_WIDTH-1:0] val_a,
  input  tag_e                      tag_b,
  input  logic [`EQ_NOUN_WIDTH-1:0] val_b,
  output verdict_e                  verdict
);

  localparam int AW = `EQ_ADDR_WIDTH;

  logic atom_match;
  logic addr_match;

  assign atom_match = (val_a == val_b);
  // A pointer only uses the low address bits
  assign addr_match = (val_a[AW-1:0] == val_b[AW-1:0]);

  always_comb begin
    if (tag_a != tag_b) begin
      verdict = V_DIFFER;
    end else if (tag_a == TAG_ATOM) begin
      if (atom_match) begin
        verdict = V_SAME;
      end else begin
        verdict = V_DIFFER;
      end
    end else begin
      // Same address means same subtree, nothing to walk
      if (addr_match) begin
        verdict = V_SAME;
      end else begin
        verdict = V_DESCEND;
      end
    end
  end

endmodule

// ==== pair_stack.sv ====
`include "equal_settings.svh"

module pair_stack (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      push,
  input  logic                      pop,
  input  logic [`EQ_ADDR_WIDTH-1:0] push_addr1,
  input  logic [`EQ_ADDR_WIDTH-1:0] push_addr2,
  output logic [`EQ_ADDR_WIDTH-1:0] top_addr1,
  output logic [`EQ_ADDR_WIDTH-1:0] top_addr2,
  output logic                      empty,
  output logic                      full
);

  localparam int DEPTH = `EQ_STACK_DEPTH;
  localparam int IDX_W = $clog2(DEPTH);
  localparam int PTR_W = $clog2(DEPTH + 1);

  logic [`EQ_ADDR_WIDTH-1:0] slot1 [DEPTH];
  logic [`EQ_ADDR_WIDTH-1:0] slot2 [DEPTH];
  // Number of pairs held
  logic [PTR_W-1:0] count;
  logic [PTR_W-1:0] top_pos;

  assign top_pos   = count - 1'b1;
  assign empty     = (count == '0);
  assign full      = (count == PTR_W'(DEPTH));
  assign top_addr1 = slot1[top_pos[IDX_W-1:0]];
  assign top_addr2 = slot2[top_pos[IDX_W-1:0]];

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      count <= '0;
    end else if (push && !pop) begin
      count <= count + 1'b1;
    end else if (pop && !push) begin
      count <= count - 1'b1;
    end
  end

  // Only entries below count are live
  always_ff @(posedge clk) begin
    if (push && pop) begin
      slot1[top_pos[IDX_W-1:0]] <= push_addr1;
      slot2[top_pos[IDX_W-1:0]] <= push_addr2;
    end else if (push) begin
      slot1[count[IDX_W-1:0]] <= push_addr1;
      slot2[count[IDX_W-1:0]] <= push_addr2;
    end
  end

endmodule

// ==== equal_fsm.sv ====
`include "equal_settings.svh"

module equal_fsm
  import noun_pkg::*;
  import equal_ctrl_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  // Command and result
  input  logic                      cmd_valid,
  output logic                      cmd_ready,
  input  logic [`EQ_ADDR_WIDTH-1:0] cmd_root,
  input  logic [`EQ_ADDR_WIDTH-1:0] cmd_dest,
  output logic                      res_valid,
  input  logic                      res_ready,
  output logic                      res_equal,
  // Memory
  output logic                      mem_req_valid,
  input  logic                      mem_req_ready,
  output mem_op_e                   mem_op,
  output logic [`EQ_ADDR_WIDTH-1:0] mem_addr1,
  output logic [`EQ_ADDR_WIDTH-1:0] mem_addr2,
  output logic [`EQ_WORD_WIDTH-1:0] mem_wdata,
  input  logic                      mem_rsp_valid,
  input  logic [`EQ_WORD_WIDTH-1:0] mem_rdata1,
  input  logic [`EQ_WORD_WIDTH-1:0] mem_rdata2,
  // Stored words and their verdicts
  output logic [`EQ_WORD_WIDTH-1:0] word1,
  output logic [`EQ_WORD_WIDTH-1:0] word2,
  input  verdict_e                  root_verdict,
  input  verdict_e                  hed_verdict,
  input  verdict_e                  tel_verdict,
  // Pair stack
  output logic                      push,
  output logic                      pop,
  output logic [`EQ_ADDR_WIDTH-1:0] push_addr1,
  output logic [`EQ_ADDR_WIDTH-1:0] push_addr2,
  input  logic [`EQ_ADDR_WIDTH-1:0] top_addr1,
  input  logic [`EQ_ADDR_WIDTH-1:0] top_addr2,
  input  logic                      empty
);

  localparam int AW = `EQ_ADDR_WIDTH;
  localparam int NW = `EQ_NOUN_WIDTH;

  state_e        state;
  logic          root_phase;
  logic          equal_r;
  logic [AW-1:0] cur_addr1;
  logic [AW-1:0] cur_addr2;
  logic [AW-1:0] dest;
  logic [AW-1:0] hed_ptr1;
  logic [AW-1:0] hed_ptr2;
  logic [AW-1:0] tel_ptr1;
  logic [AW-1:0] tel_ptr2;
  logic          any_differ;
  logic          hed_down;
  logic          tel_down;
  logic          pair_decide;

  // Pointer parts of the stored hed and tel fields
  assign hed_ptr1 = word1[NW+AW-1:NW];
  assign hed_ptr2 = word2[NW+AW-1:NW];
  assign tel_ptr1 = word1[AW-1:0];
  assign tel_ptr2 = word2[AW-1:0];

  assign any_differ  = (hed_verdict == V_DIFFER) || (tel_verdict == V_DIFFER);
  assign hed_down    = (hed_verdict == V_DESCEND);
  assign tel_down    = (tel_verdict == V_DESCEND);
  assign pair_decide = (state == S_DECIDE) && !root_phase && !any_differ;

  assign cmd_ready     = (state == S_IDLE) && empty;
  assign res_valid     = (state == S_REPORT);
  assign res_equal     = equal_r;
  assign mem_req_valid = (state == S_ROOT_REQ) || (state == S_PAIR_REQ) || (state == S_WRITE);
  assign mem_op        = (state == S_WRITE) ? MEM_WRITE : MEM_READ;
  assign mem_addr1     = (state == S_WRITE) ? dest : cur_addr1;
  assign mem_addr2     = cur_addr2;
  // Result cell has two atom tags, the verdict and a NIL tel
  assign mem_wdata     = {TAG_ATOM, TAG_ATOM, equal_r ? `EQ_YES : `EQ_NO, `EQ_NIL};

  // Tel pair waits on the stack while the hed pair is walked
  assign push       = pair_decide && hed_down && tel_down;
  // Pairs left behind by an early NO drain while idle
  assign pop        = (pair_decide && !hed_down && !tel_down && !empty) ||
                      ((state == S_IDLE) && !empty);
  assign push_addr1 = tel_ptr1;
  assign push_addr2 = tel_ptr2;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state      <= S_IDLE;
      root_phase <= 1'b0;
      equal_r    <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (cmd_valid && cmd_ready) begin
            state      <= S_ROOT_REQ;
            root_phase <= 1'b1;
          end
        end
        S_ROOT_REQ: if (mem_req_ready) state <= S_ROOT_WAIT;
        S_ROOT_WAIT: if (mem_rsp_valid) state <= S_DECIDE;
        S_PAIR_REQ: if (mem_req_ready) state <= S_PAIR_WAIT;
        S_PAIR_WAIT: if (mem_rsp_valid) state <= S_DECIDE;
        S_DECIDE: begin
          root_phase <= 1'b0;
          if (root_phase) begin
            // Root hed against root tel
            case (root_verdict)
              V_DIFFER: begin
                equal_r <= 1'b0;
                state   <= S_WRITE;
              end
              V_SAME: begin
                equal_r <= 1'b1;
                state   <= S_WRITE;
              end
              default: state <= S_PAIR_REQ;
            endcase
          end else if (any_differ) begin
            equal_r <= 1'b0;
            state   <= S_WRITE;
          end else if (hed_down || tel_down || !empty) begin
            state <= S_PAIR_REQ;
          end else begin
            // Nothing left to walk
            equal_r <= 1'b1;
            state   <= S_WRITE;
          end
        end
        S_WRITE: if (mem_req_ready) state <= S_REPORT;
        S_REPORT: if (res_ready) state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_valid && cmd_ready) begin
      dest      <= cmd_dest;
      cur_addr1 <= cmd_root;
      cur_addr2 <= cmd_root;
    end
    if (mem_rsp_valid && (state == S_ROOT_WAIT || state == S_PAIR_WAIT)) begin
      word1 <= mem_rdata1;
      word2 <= mem_rdata2;
    end
    if (state == S_DECIDE) begin
      if (root_phase) begin
        cur_addr1 <= hed_ptr1;
        cur_addr2 <= tel_ptr1;
      end else if (hed_down) begin
        cur_addr1 <= hed_ptr1;
        cur_addr2 <= hed_ptr2;
      end else if (tel_down) begin
        cur_addr1 <= tel_ptr1;
        cur_addr2 <= tel_ptr2;
      end else begin
        cur_addr1 <= top_addr1;
        cur_addr2 <= top_addr2;
      end
    end
  end

endmodule

// ==== equal_top.sv ====
`include "equal_settings.svh"

module equal_top
  import noun_pkg::*;
  import equal_ctrl_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      cmd_valid,
  output logic                      cmd_ready,
  input  logic [`EQ_ADDR_WIDTH-1:0] cmd_root,
  input  logic [`EQ_ADDR_WIDTH-1:0] cmd_dest,
  output logic                      res_valid,
  input  logic                      res_ready,
  output logic                      res_equal,
  output logic                      mem_req_valid,
  input  logic                      mem_req_ready,
  output mem_op_e                   mem_op,
  output logic [`EQ_ADDR_WIDTH-1:0] mem_addr1,
  output logic [`EQ_ADDR_WIDTH-1:0] mem_addr2,
  output logic [`EQ_WORD_WIDTH-1:0] mem_wdata,
  input  logic                      mem_rsp_valid,
  input  logic [`EQ_WORD_WIDTH-1:0] mem_rdata1,
  input  logic [`EQ_WORD_WIDTH-1:0] mem_rdata2
);

  localparam int NW = `EQ_NOUN_WIDTH;

  logic [`EQ_WORD_WIDTH-1:0] word1;
  logic [`EQ_WORD_WIDTH-1:0] word2;
  verdict_e                  root_verdict;
  verdict_e                  hed_verdict;
  verdict_e                  tel_verdict;
  logic                      push;
  logic                      pop;
  logic [`EQ_ADDR_WIDTH-1:0] push_addr1;
  logic [`EQ_ADDR_WIDTH-1:0] push_addr2;
  logic [`EQ_ADDR_WIDTH-1:0] top_addr1;
  logic [`EQ_ADDR_WIDTH-1:0] top_addr2;
  logic                      stack_empty;
  logic                      stack_full;

  equal_fsm fsm_i (
    .clk, .rst, .cmd_valid, .cmd_ready, .cmd_root, .cmd_dest,
    .res_valid, .res_ready, .res_equal,
    .mem_req_valid, .mem_req_ready, .mem_op, .mem_addr1, .mem_addr2, .mem_wdata,
    .mem_rsp_valid, .mem_rdata1, .mem_rdata2,
    .word1, .word2, .root_verdict, .hed_verdict, .tel_verdict,
    .push, .pop, .push_addr1, .push_addr2, .top_addr1, .top_addr2,
    .empty(stack_empty)
  );

  pair_stack stack_i (
    .clk, .rst, .push, .pop, .push_addr1, .push_addr2, .top_addr1, .top_addr2,
    .empty(stack_empty), .full(stack_full)
  );

  // Root cell hed against its own tel
  field_compare root_cmp (
    .tag_a(tag_e'(word1[`EQ_HED_TAG_BIT])), .val_a(word1[2*NW-1:NW]),
    .tag_b(tag_e'(word1[`EQ_TEL_TAG_BIT])), .val_b(word1[NW-1:0]),
    .verdict(root_verdict)
  );

  field_compare hed_cmp (
    .tag_a(tag_e'(word1[`EQ_HED_TAG_BIT])), .val_a(word1[2*NW-1:NW]),
    .tag_b(tag_e'(word2[`EQ_HED_TAG_BIT])), .val_b(word2[2*NW-1:NW]),
    .verdict(hed_verdict)
  );

  field_compare tel_cmp (
    .tag_a(tag_e'(word1[`EQ_TEL_TAG_BIT])), .val_a(word1[NW-1:0]),
    .tag_b(tag_e'(word2[`EQ_TEL_TAG_BIT])), .val_b(word2[NW-1:0]),
    .verdict(tel_verdict)
  );

endmodule

// ==== equal_checker.sv ====
`include "equal_settings.svh"

module equal_checker
  import equal_ctrl_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic [127:0]              exp_name,
  input  logic [`EQ_ADDR_WIDTH-1:0] exp_dest,
  input  logic                      exp_equal,
  input  logic                      res_valid,
  input  logic                      res_ready,
  input  logic                      res_equal,
  input  logic                      mem_req_valid,
  input  logic                      mem_req_ready,
  input  mem_op_e                   mem_op,
  input  logic [`EQ_ADDR_WIDTH-1:0] mem_addr1,
  input  logic [`EQ_WORD_WIDTH-1:0] mem_wdata,
  output int                        value_errors,
  output int                        other_errors
);

  logic [`EQ_WORD_WIDTH-1:0] exp_word;
  int                        writes_seen;
  int                        results_seen;

  // Result cell: atom tags, verdict atom as hed, NIL as tel
  assign exp_word = {2'b00, exp_equal ? `EQ_YES : `EQ_NO, `EQ_NIL};

  initial begin
    value_errors = 0;
    other_errors = 0;
    writes_seen  = 0;
    results_seen = 0;
  end

  always @(posedge clk) begin
    if (rst && mem_req_valid && mem_req_ready && mem_op == MEM_WRITE) begin
      writes_seen = writes_seen + 1;
      if (mem_addr1 !== exp_dest) begin
        value_errors = value_errors + 1;
        $display("error %0s: write address expected %h, actual %h",
                 exp_name, exp_dest, mem_addr1);
      end
      if (mem_wdata !== exp_word) begin
        value_errors = value_errors + 1;
        $display("error %0s: result cell expected %h, actual %h",
                 exp_name, exp_word, mem_wdata);
      end
    end
    if (rst && res_valid && res_ready) begin
      if (res_equal !== exp_equal) begin
        value_errors = value_errors + 1;
        $display("error %0s: res_equal expected %0d, actual %0d",
                 exp_name, exp_equal, res_equal);
      end
      if (writes_seen != 1) begin
        other_errors = other_errors + 1;
        $display("%0s: the result came after %0d cell writes instead of one",
                 exp_name, writes_seen);
      end
      writes_seen  = 0;
      results_seen = results_seen + 1;
    end
  end

  task print_summary(input int assert_fails);
    $display("results %0d, value errors %0d, other errors %0d, assertion failures %0d",
             results_seen, value_errors, other_errors, assert_fails);
  endtask

endmodule

// ==== equal_assert.sv ====
`include "equal_settings.svh"

module equal_assert
  import equal_ctrl_pkg::*;
(
  input logic                      clk,
  input logic                      rst,
  input logic                      cmd_ready,
  input logic                      res_valid,
  input logic                      res_ready,
  input logic                      res_equal,
  input logic                      mem_req_valid,
  input logic                      mem_req_ready,
  input mem_op_e                   mem_op,
  input logic [`EQ_ADDR_WIDTH-1:0] mem_addr1,
  input logic [`EQ_ADDR_WIDTH-1:0] mem_addr2,
  input logic [`EQ_WORD_WIDTH-1:0] mem_wdata,
  input logic                      push,
  input logic                      stack_full
);

  // Number of assertion failures so far
  int assert_fails = 0;

  // A stalled request keeps all of its fields
  req_hold: assert property (@(posedge clk) disable iff (!rst)
    mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_op) &&
    $stable(mem_addr1) && $stable(mem_addr2) && $stable(mem_wdata))
    else begin
      $error("memory request changed before it was accepted");
      assert_fails = assert_fails + 1;
    end

  res_hold: assert property (@(posedge clk) disable iff (!rst)
    res_valid && !res_ready |=> res_valid && $stable(res_equal))
    else begin
      $error("result dropped or changed before it was accepted");
      assert_fails = assert_fails + 1;
    end

  no_cmd_during_res: assert property (@(posedge clk) disable iff (!rst)
    !(cmd_ready && res_valid))
    else begin
      $error("command accepted while a result is pending");
      assert_fails = assert_fails + 1;
    end

  // Checked in the first cycle out of reset
  quiet_after_reset: assert property (@(posedge clk) $rose(rst) |-> !mem_req_valid)
    else begin
      $error("memory request right after reset");
      assert_fails = assert_fails + 1;
    end

  no_overflow: assert property (@(posedge clk) disable iff (!rst)
    !(push && stack_full))
    else begin
      $error("pair stack pushed while full");
      assert_fails = assert_fails + 1;
    end

endmodule

bind equal_top equal_assert assert_i (.*);

// ==== tb_equal.sv ====
`include "equal_settings.svh"

module tb_equal
  import equal_ctrl_pkg::*;
();

  localparam int AW = `EQ_ADDR_WIDTH;
  localparam int WW = `EQ_WORD_WIDTH;

  logic          clk;
  logic          rst;
  logic          cmd_valid;
  logic          cmd_ready;
  logic [AW-1:0] cmd_root;
  logic [AW-1:0] cmd_dest;
  logic          res_valid;
  logic          res_ready;
  logic          res_equal;
  logic          mem_req_valid;
  logic          mem_req_ready;
  mem_op_e       mem_op;
  logic [AW-1:0] mem_addr1;
  logic [AW-1:0] mem_addr2;
  logic [WW-1:0] mem_wdata;
  logic          mem_rsp_valid;
  logic [WW-1:0] mem_rdata1;
  logic [WW-1:0] mem_rdata2;

  logic [WW-1:0]  mem [256];
  logic [127:0]   cmd_names [32];
  logic [AW-1:0]  cmd_roots [32];
  logic [AW-1:0]  cmd_dests [32];
  logic           cmd_expects [32];
  int             n_cmds;
  logic [127:0]   cur_name;
  logic [AW-1:0]  cur_dest;
  logic           cur_expect;
  logic [AW-1:0]  rd_addr1;
  logic [AW-1:0]  rd_addr2;
  int             rd_wait;
  int             cycles;
  int             limit;
  int             value_errors;
  int             other_errors;
  int unsigned    seed_draw;

  equal_top dut_i (
    .clk, .rst, .cmd_valid, .cmd_ready, .cmd_root, .cmd_dest,
    .res_valid, .res_ready, .res_equal,
    .mem_req_valid, .mem_req_ready, .mem_op, .mem_addr1, .mem_addr2, .mem_wdata,
    .mem_rsp_valid, .mem_rdata1, .mem_rdata2
  );

  equal_checker chk_i (
    .clk, .rst, .exp_name(cur_name), .exp_dest(cur_dest), .exp_equal(cur_expect),
    .res_valid, .res_ready, .res_equal, .mem_req_valid, .mem_req_ready, .mem_op,
    .mem_addr1, .mem_wdata, .value_errors, .other_errors
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic load_testdata();
    int           fd;
    int           n;
    logic [639:0] line;
    logic [63:0]  kind;
    logic [127:0] name;
    logic [31:0]  addr;
    logic [31:0]  dest;
    logic [31:0]  expect_eq;
    logic [WW-1:0] word;
    fd = $fopen("equal_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open equal_testdata.txt");
    end else begin
      while (!$feof(fd)) begin
        line = '0;
        kind = '0;
        n = $fgets(line, fd);
        n = $sscanf(line, "%s", kind);
        if (kind == "M") begin
          n = $sscanf(line, "%s %h %h", kind, addr, word);
          mem[addr[AW-1:0]] = word;
        end else if (kind == "C") begin
          n = $sscanf(line, "%s %s %h %h %d", kind, name, addr, dest, expect_eq);
          cmd_names[n_cmds]   = name;
          cmd_roots[n_cmds]   = addr[AW-1:0];
          cmd_dests[n_cmds]   = dest[AW-1:0];
          cmd_expects[n_cmds] = expect_eq[0];
          n_cmds = n_cmds + 1;
        end
      end
      $fclose(fd);
    end
  endtask

  // One command, then wait for its result to be taken
  task automatic run_command(input int idx);
    @(negedge clk);
    cur_name   = cmd_names[idx];
    cur_dest   = cmd_dests[idx];
    cur_expect = cmd_expects[idx];
    cmd_root   = cmd_roots[idx];
    cmd_dest   = cmd_dests[idx];
    cmd_valid  = 1'b1;
    @(posedge clk);
    while (!cmd_ready) @(posedge clk);
    @(negedge clk);
    cmd_valid = 1'b0;
    @(posedge clk);
    while (!(res_valid && res_ready)) @(posedge clk);
  endtask

  // Memory model and random stalls, all on the falling edge
  always @(negedge clk) begin
    mem_rsp_valid = 1'b0;
    if (rd_wait > 0) begin
      rd_wait = rd_wait - 1;
      if (rd_wait == 0) begin
        mem_rsp_valid = 1'b1;
        mem_rdata1    = mem[rd_addr1];
        mem_rdata2    = mem[rd_addr2];
      end
    end
    mem_req_ready = ($urandom % 4) != 0;
    res_ready     = ($urandom % 3) != 0;
    // Valid and ready now hold until the next rising edge accepts them
    if (rst && mem_req_valid && mem_req_ready) begin
      if (mem_op == MEM_WRITE) begin
        mem[mem_addr1] = mem_wdata;
      end else begin
        rd_addr1 = mem_addr1;
        rd_addr2 = mem_addr2;
        rd_wait  = 1 + ($urandom % 3);
      end
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= limit) begin
      $display("timeout: the run did not finish within %0d cycles", limit);
      chk_i.print_summary(dut_i.assert_i.assert_fails);
      $display("TB FAILED");
      $finish;
    end
  end

  initial begin
    seed_draw     = $urandom(32'ha64a9325);
    rst           = 1'b0;
    cmd_valid     = 1'b0;
    cmd_root      = '0;
    cmd_dest      = '0;
    res_ready     = 1'b0;
    mem_req_ready = 1'b0;
    mem_rsp_valid = 1'b0;
    mem_rdata1    = '0;
    mem_rdata2    = '0;
    cur_name      = '0;
    cur_dest      = '0;
    cur_expect    = 1'b0;
    rd_wait       = 0;
    cycles        = 0;
    n_cmds        = 0;
    // Unused words still differ with every address bit
    for (int i = 0; i < 256; i++) begin
      mem[i] = {2'b00, 8'h5a, i[7:0], ~i[7:0], i[7:0]};
    end
    load_testdata();
    limit = 400 * n_cmds + 100;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b1;
    for (int i = 0; i < n_cmds; i++) begin
      run_command(i);
    end
    @(negedge clk);
    if (n_cmds == 0) begin
      $display("no commands were read from equal_testdata.txt");
    end
    chk_i.print_summary(dut_i.assert_i.assert_fails);
    if (n_cmds > 0 && value_errors == 0 && other_errors == 0 &&
        dut_i.assert_i.assert_fails == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== equal_testdata.txt ====
# M <addr> <cell word>: word is {hed tag, tel tag, hed, tel} as 9 hex digits
# C <name> <root> <dest> <equal>: equal is the expected res_equal, 1 for YES
M 10 000050005
M 11 000050007
M 12 100050020
M 30 300400050
M 31 300400060
M 32 300400040
M 40 300410042
M 41 000010002
M 42 200430003
M 43 000040005
M 50 300510052
M 51 000010002
M 52 200530003
M 53 000040005
M 60 300610062
M 61 000010002
M 62 200630003
M 63 000040006
C eq_atoms 10 80 1
C ne_atoms 11 81 0
C tag_mix 12 82 0
C deep_same 30 83 1
C deep_right 31 84 0
C same_ptr 32 85 1

// ==== filelist.f ====
+incdir+.
noun_pkg.sv
equal_ctrl_pkg.sv
field_compare.sv
pair_stack.sv
equal_fsm.sv
equal_top.sv
equal_checker.sv
equal_assert.sv
tb_equal.sv

// ==== Bender.yml ====
package:
  name: tree_equal

export_include_dirs:
  - .

sources:
  - noun_pkg.sv
  - equal_ctrl_pkg.sv
  - field_compare.sv
  - pair_stack.sv
  - equal_fsm.sv
  - equal_top.sv
  - target: test
    files:
      - equal_checker.sv
      - equal_assert.sv
      - tb_equal.sv
